/* common/UartPkg.sv */
package UartPkg;

   // One character on the line
   typedef logic [7:0] dataByte;

   // Start bit in bit 0, stop bit in bit 9
   typedef logic [9:0] frameBits;

   typedef logic [7:0] echoCount;   // Wraps at 256

   typedef enum logic [1:0] {
      WaitStartBit,
      StartReceiving,
      Receiving,
      Received
   } rxState;

   localparam int DefaultFreq = 50000000;   // Board clock
   localparam int DefaultBaud = 115200;

   // Start + 8 data + stop
   localparam int BitCount = 10;

endpackage

/* rs232rx/Rs232Rx.sv */
`timescale 1ns/10ps

module Rs232Rx #(
   parameter int FREQ = UartPkg::DefaultFreq,
   parameter int BAUD = UartPkg::DefaultBaud
) (
   input  logic             CLK50MHZ,
   input  logic             RST,
   input  logic             RxD,
   output UartPkg::dataByte RxData,
   output logic             RxDataReady,
   output logic             FrameError
);

   localparam int AccWidth = $clog2(FREQ);
   localparam longint FastInc = ((longint'(3 * BAUD) << AccWidth) + FREQ / 2) / FREQ;
   localparam longint BitInc = ((longint'(BAUD) << AccWidth) + FREQ / 2) / FREQ;

   UartPkg::rxState   state;
   UartPkg::frameBits frame;
   logic              receiving;
   logic              trig;
   logic              fastTick;
   logic              bitTick;
   logic [2:0]        rx3;
   logic              vote;
   logic              bitDue;
   logic              voteTick;
   logic              desReady;

   BaudRateGenerator #(
      .INC(int'(FastInc)),   // Three samples per bit
      .N(AccWidth)
   ) sampleGen (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .en(receiving),
      .tick(fastTick)
   );

   BaudRateGenerator #(
      .INC(int'(BitInc)),
      .N(AccWidth)
   ) bitGen (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .en(receiving),
      .tick(bitTick)
   );

   always_ff @(posedge CLK50MHZ) begin
      if (fastTick) begin
         rx3 <= {rx3[1:0], RxD};
      end
   end

   assign vote = (rx3[0] & rx3[1]) | (rx3[1] & rx3[2]) | (rx3[0] & rx3[2]);

   // The mid-bit tick only arms the vote. It is taken after the
   // following sample, once all three samples belong to this bit
   always_ff @(posedge CLK50MHZ) begin
      if (RST || !receiving) begin
         bitDue <= 1'b0;
         voteTick <= 1'b0;
      end else begin
         voteTick <= bitDue && fastTick && !bitTick;
         if (bitTick) begin
            bitDue <= 1'b1;
         end else if (fastTick) begin
            bitDue <= 1'b0;
         end
      end
   end

   RxDeserializer deserializer (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .rx(vote),
      .tick(voteTick),
      .trig(trig),
      .data(frame),
      .ready(desReady)
   );

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         state <= UartPkg::WaitStartBit;
      end else begin
         case (state)
            UartPkg::WaitStartBit: if (!RxD) state <= UartPkg::StartReceiving;
            UartPkg::StartReceiving: state <= UartPkg::Receiving;
            UartPkg::Receiving: if (desReady) state <= UartPkg::Received;
            default: state <= UartPkg::WaitStartBit;
         endcase
      end
   end

   assign trig = (state == UartPkg::StartReceiving);
   assign receiving = (state == UartPkg::Receiving);
   assign RxDataReady = (state == UartPkg::Received);
   assign RxData = frame[8:1];                  // Strip start and stop
   assign FrameError = RxDataReady && !frame[9];

   readyPulse: assert property (@(posedge CLK50MHZ) disable iff (RST)
      RxDataReady |=> !RxDataReady);

endmodule

/* rs232rx/RxDeserializer.sv */
`timescale 1ns/10ps

module RxDeserializer (
   input  logic              CLK50MHZ,
   input  logic              RST,
   input  logic              rx,
   input  logic              tick,
   input  logic              trig,
   output UartPkg::frameBits data,
   output logic              ready
);

   localparam int CntWidth = $clog2(UartPkg::BitCount);

   logic [CntWidth-1:0] bitCnt;

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         bitCnt <= '0;
         ready <= 1'b0;
      end else if (trig) begin
         bitCnt <= '0;
         ready <= 1'b0;
      end else begin
         ready <= tick && (bitCnt == CntWidth'(UartPkg::BitCount - 1));
         if (tick) begin
            bitCnt <= bitCnt + 1'b1;
         end
      end
   end

   // LSB first on the line, so new bits enter at the top
   always_ff @(posedge CLK50MHZ) begin
      if (trig) begin
         data <= '0;
      end else if (tick) begin
         data <= {rx, data[9:1]};
      end
   end

   // Next frame cannot start until the FSM has seen ready
   noTickOnReady: assert property (@(posedge CLK50MHZ) disable iff (RST)
      ready |-> !tick);

endmodule

/* rs232tx/Rs232Tx.sv */
`timescale 1ns/10ps

module Rs232Tx #(
   parameter int FREQ = UartPkg::DefaultFreq,
   parameter int BAUD = UartPkg::DefaultBaud
) (
   input  logic             CLK50MHZ,
   input  logic             RST,
   input  UartPkg::dataByte TxData,
   input  logic             TxStart,
   output logic             TxD,
   output logic             TxBusy
);

   localparam int AccWidth = $clog2(FREQ);
   localparam longint HalfInc = ((longint'(2 * BAUD) << AccWidth) + FREQ / 2) / FREQ;
   localparam int CntWidth = $clog2(UartPkg::BitCount);

   logic                halfTick;
   logic                secondHalf;
   logic [CntWidth-1:0] bitCnt;
   UartPkg::frameBits   shifter;

   // Runs at twice the bit rate. With the half-scale preset the first
   // tick lands a quarter bit in, so the start bit is a bit short
   BaudRateGenerator #(
      .INC(int'(HalfInc)),
      .N(AccWidth)
   ) halfBitGen (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .en(TxBusy),
      .tick(halfTick)
   );

   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         TxBusy <= 1'b0;
         shifter <= '1;   // Line idles high
         bitCnt <= '0;
         secondHalf <= 1'b0;
      end else if (TxStart) begin
         TxBusy <= 1'b1;
         shifter <= {1'b1, TxData, 1'b0};
         bitCnt <= '0;
         secondHalf <= 1'b0;
      end else if (halfTick) begin
         secondHalf <= !secondHalf;
         if (secondHalf) begin
            shifter <= {1'b1, shifter[9:1]};   // Ones fill behind the stop bit
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == CntWidth'(UartPkg::BitCount - 1)) begin
               TxBusy <= 1'b0;   // Stop bit done
            end
         end
      end
   end

   assign TxD = shifter[0];

   startWhenFree: assert property (@(posedge CLK50MHZ) disable iff (RST)
      TxStart |-> !TxBusy);

endmodule

/* rtl/BaudRateGenerator.sv */
`timescale 1ns/10ps

module BaudRateGenerator #(
   parameter int INC = 302,
   parameter int N = 17
) (
   input  logic CLK50MHZ,
   input  logic RST,
   input  logic en,
   output logic tick
);

   logic [N:0] acc;   // Top bit is the carry

   always_ff @(posedge CLK50MHZ) begin
      if (RST || !en) begin
         acc <= {2'b01, {(N - 1){1'b0}}};   // Half scale, first tick mid-period
      end else begin
         acc <= {1'b0, acc[N-1:0]} + (N + 1)'(INC);
      end
   end

   assign tick = acc[N];

endmodule

/* rtl/EchoCtrl.sv */
`timescale 1ns/10ps

module EchoCtrl (
   input  logic              CLK50MHZ,
   input  logic              RST,
   input  UartPkg::dataByte  RxData,
   input  logic              RxDataReady,
   input  logic              FrameError,
   input  logic              TxBusy,
   output UartPkg::dataByte  TxData,
   output logic              TxStart,
   output UartPkg::echoCount EchoCount
);

   logic pending;
   logic goodByte;

   function automatic UartPkg::dataByte toUpper(input UartPkg::dataByte c);
      if (c >= 8'h61 && c <= 8'h7A) begin
         return c - 8'h20;   // a..z to A..Z
      end
      return c;
   endfunction

   assign goodByte = RxDataReady && !FrameError;

   always_ff @(posedge CLK50MHZ) begin
      if (goodByte) begin
         TxData <= toUpper(RxData);   // A late byte overwrites a held one
      end
   end

   // TxBusy only rises the cycle after TxStart, hence the TxStart guard
   always_ff @(posedge CLK50MHZ) begin
      if (RST) begin
         pending <= 1'b0;
         TxStart <= 1'b0;
         EchoCount <= '0;
      end else begin
         TxStart <= 1'b0;
         if (pending && !TxBusy && !TxStart) begin
            TxStart <= 1'b1;
            pending <= 1'b0;
            EchoCount <= EchoCount + 1'b1;
         end
         if (goodByte) begin
            pending <= 1'b1;
         end
      end
   end

endmodule

/* rtl/UartEcho.sv */
`timescale 1ns/10ps

module UartEcho #(
   parameter int FREQ = UartPkg::DefaultFreq,
   parameter int BAUD = UartPkg::DefaultBaud
) (
   input  logic              CLK50MHZ,
   input  logic              RST,
   input  logic              RxD,
   output logic              TxD,
   output UartPkg::dataByte  RxData,
   output logic              RxDataReady,
   output logic              FrameError,
   output UartPkg::echoCount EchoCount
);

   UartPkg::dataByte txData;
   logic             txStart;
   logic             txBusy;

   Rs232Rx #(
      .FREQ(FREQ),
      .BAUD(BAUD)
   ) rx (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .RxD(RxD),
      .RxData(RxData),
      .RxDataReady(RxDataReady),
      .FrameError(FrameError)
   );

   EchoCtrl echo (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .RxData(RxData),
      .RxDataReady(RxDataReady),
      .FrameError(FrameError),
      .TxBusy(txBusy),
      .TxData(txData),
      .TxStart(txStart),
      .EchoCount(EchoCount)
   );

   Rs232Tx #(
      .FREQ(FREQ),
      .BAUD(BAUD)
   ) tx (
      .CLK50MHZ(CLK50MHZ),
      .RST(RST),
      .TxData(txData),
      .TxStart(txStart),
      .TxD(TxD),
      .TxBusy(txBusy)
   );

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the UART echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module UartEchoTb \
   --Mdir obj_dir -o UartEchoSim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Build failed"
   exit 1
fi

./obj_dir/UartEchoSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Verification failed" sim.log; then
   exit 1
fi
exit 0

/* sim.f */
common/UartPkg.sv
rtl/BaudRateGenerator.sv
rs232rx/RxDeserializer.sv
rs232rx/Rs232Rx.sv
rs232tx/Rs232Tx.sv
rtl/EchoCtrl.sv
rtl/UartEcho.sv
tb/UartEchoTb.sv

/* tb/UartEchoTb.sv */
`timescale 1ns/10ps

module UartEchoTb;

   localparam int BitCycles = UartPkg::DefaultFreq / UartPkg::DefaultBaud;   // Clocks per bit
   localparam int MaxTests = 16;

   logic              CLK50MHZ = 1'b0;
   logic              RST;
   logic              RxD;
   logic              TxD;
   UartPkg::dataByte  RxData;
   logic              RxDataReady;
   logic              FrameError;
   UartPkg::echoCount EchoCount;

   // Stimulus table, one entry per frame
   UartPkg::dataByte txByte [MaxTests];
   logic             stopBit [MaxTests];
   UartPkg::dataByte echoByte [MaxTests];
   int               gapBits [MaxTests];
   logic             failed [MaxTests];
   int               numTests = 0;

   logic [16:0] rxSeen [$];      // {EchoCount, FrameError, RxData} per RxDataReady
   int          echoOrder [$];   // Entries still waiting for their echo
   int          passCount = 0;
   int          failCount = 0;
   int          errorCount = 0;
   int          seed = 34904;
   logic        resetDone = 1'b0;

   UartEcho DUT (.*);

   always #10 CLK50MHZ = ~CLK50MHZ;

   // Letters differ from capitals only in bit 5
   function automatic UartPkg::dataByte upperOf(input UartPkg::dataByte b);
      if (b >= 8'h61 && b <= 8'h7A) begin
         return b & 8'hDF;
      end
      return b;
   endfunction

   task automatic addEntry(input UartPkg::dataByte b, input logic stop,
                           input UartPkg::dataByte echo, input int gap);
      txByte[numTests] = b;
      stopBit[numTests] = stop;
      echoByte[numTests] = echo;
      gapBits[numTests] = gap;
      failed[numTests] = 1'b0;
      if (stop) begin
         echoOrder.push_back(numTests);
      end
      numTests++;
   endtask

   task automatic fillTable();
      int i;
      int r;
      addEntry(8'h61, 1'b1, 8'h41, 2);   // a
      addEntry(8'h7A, 1'b1, 8'h5A, 1);   // z
      addEntry(8'h4D, 1'b1, 8'h4D, 1);
      addEntry(8'h60, 1'b1, 8'h60, 1);   // One below a
      addEntry(8'h7B, 1'b1, 8'h7B, 1);   // One above z
      addEntry(8'hE1, 1'b1, 8'hE1, 1);
      // A zero stop bit reads as a new start, so a frame follows at once
      addEntry(8'h71, 1'b0, 8'h00, 0);
      addEntry(8'h72, 1'b1, 8'h52, 0);
      addEntry(8'h73, 1'b1, 8'h53, 0);
      addEntry(8'h31, 1'b1, 8'h31, 0);
      addEntry(8'h74, 1'b1, 8'h54, 2);
      for (i = 0; i < 4; i++) begin
         r = $random(seed);
         addEntry(r[7:0], 1'b1, upperOf(r[7:0]), (i == 3) ? 1 : i % 2);
      end
   endtask

   // Called on a falling edge
   task automatic sendFrame(input UartPkg::dataByte b, input logic stop, input int gap);
      logic [9:0] bits;
      int i;
      bits = {stop, b, 1'b0};
      for (i = 0; i < 10; i++) begin
         RxD = bits[i];
         repeat (BitCycles) @(negedge CLK50MHZ);
      end
      RxD = 1'b1;
      repeat (gap * BitCycles) @(negedge CLK50MHZ);
   endtask

   task automatic reportTest(input int i);
      if (failed[i]) begin
         $display("Test %0d: byte 0x%h FAILED", i, txByte[i]);
         failCount++;
      end else begin
         $display("Test %0d: byte 0x%h ok", i, txByte[i]);
         passCount++;
      end
   endtask

   task automatic checkEcho(input UartPkg::dataByte b);
      int idx;
      if (echoOrder.size() == 0) begin
         $display("Byte 0x%h appeared on TxD although no frame was waiting for an echo",
                  b);
         errorCount++;
      end else begin
         idx = echoOrder.pop_front();
         if (b !== echoByte[idx]) begin
            $display("** Error: TxD expected 0x%h got 0x%h (test %0d)",
                     echoByte[idx], b, idx);
            failed[idx] = 1'b1;
         end
         reportTest(idx);
      end
   endtask

   initial begin : watchRx
      wait (resetDone);
      forever begin
         @(negedge CLK50MHZ);
         if (RxDataReady) begin
            rxSeen.push_back({EchoCount, FrameError, RxData});
         end
         if (FrameError && !RxDataReady) begin
            $display("FrameError went high without RxDataReady at %0t", $time);
            errorCount++;
         end
      end
   end

   initial begin : decodeTx
      UartPkg::dataByte b;
      int i;
      wait (resetDone);
      forever begin
         @(negedge TxD);
         repeat (BitCycles * 3 / 8) @(negedge CLK50MHZ);   // Tx start bit is 3/4 bit long
         if (TxD !== 1'b0) begin
            $display("Start bit on TxD did not stay low at %0t", $time);
            errorCount++;
         end
         repeat (BitCycles * 7 / 8) @(negedge CLK50MHZ);
         for (i = 0; i < 8; i++) begin
            b[i] = TxD;
            repeat (BitCycles) @(negedge CLK50MHZ);
         end
         if (TxD !== 1'b1) begin
            $display("Stop bit on TxD was not high at %0t", $time);
            errorCount++;
         end
         checkEcho(b);
      end
   end

   initial begin : watchdog
      repeat ((MaxTests * 12 + 48) * BitCycles) @(posedge CLK50MHZ);
      $display("Timeout: the run did not end within its time limit");
      $display("Verification failed");
      $finish;
   end

   initial begin : mainFlow
      UartPkg::echoCount goodBefore;
      logic [16:0] seen;
      int i;
      int n;
      RST = 1'b1;
      RxD = 1'b1;
      goodBefore = '0;
      fillTable();
      repeat (5) @(negedge CLK50MHZ);
      RST = 1'b0;
      @(negedge CLK50MHZ);
      resetDone = 1'b1;
      if (TxD !== 1'b1 || EchoCount !== 8'h00 ||
          RxDataReady !== 1'b0 || FrameError !== 1'b0) begin
         $display("** Error: after reset TxD=%h EchoCount=%h RxDataReady=%h FrameError=%h",
                  TxD, EchoCount, RxDataReady, FrameError);
         failCount++;
      end else begin
         $display("Test reset: ok");
         passCount++;
      end
      for (i = 0; i < numTests; i++) begin
         sendFrame(txByte[i], stopBit[i], gapBits[i]);
         n = 0;
         while (rxSeen.size() == 0 && n < 2 * BitCycles) begin
            @(negedge CLK50MHZ);
            n++;
         end
         if (rxSeen.size() == 0) begin
            $display("Test %0d: RxDataReady never pulsed for byte 0x%h", i, txByte[i]);
            failed[i] = 1'b1;
         end else begin
            seen = rxSeen.pop_front();
            if (seen[7:0] !== txByte[i]) begin
               $display("** Error: RxData expected 0x%h got 0x%h (test %0d)",
                        txByte[i], seen[7:0], i);
               failed[i] = 1'b1;
            end
            if (seen[8] !== ~stopBit[i]) begin
               $display("** Error: FrameError expected 0x%h got 0x%h (test %0d)",
                        ~stopBit[i], seen[8], i);
               failed[i] = 1'b1;
            end
            if (seen[16:9] !== goodBefore) begin
               $display("** Error: EchoCount expected 0x%h got 0x%h (test %0d)",
                        goodBefore, seen[16:9], i);
               failed[i] = 1'b1;
            end
         end
         if (stopBit[i]) begin
            goodBefore = goodBefore + 8'd1;
         end else begin
            reportTest(i);   // Nothing to echo
         end
      end
      n = 0;
      while (echoOrder.size() != 0 && n < 24 * BitCycles) begin
         @(negedge CLK50MHZ);
         n++;
      end
      while (echoOrder.size() != 0) begin
         $display("Test %0d: byte 0x%h was never echoed on TxD",
                  echoOrder[0], txByte[echoOrder[0]]);
         failed[echoOrder[0]] = 1'b1;
         reportTest(echoOrder.pop_front());
      end
      repeat (12 * BitCycles) @(negedge CLK50MHZ);   // Quiet line, catches stray frames
      if (EchoCount !== goodBefore) begin
         $display("** Error: EchoCount expected 0x%h got 0x%h at the end",
                  goodBefore, EchoCount);
         errorCount++;
      end
      if (rxSeen.size() != 0) begin
         $display("RxDataReady pulsed %0d more times than frames were sent", rxSeen.size());
         errorCount++;
      end
      $display("Tests passed: %0d, tests failed: %0d, other errors: %0d",
               passCount, failCount, errorCount);
      if (failCount == 0 && errorCount == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
